/* files.f */
+incdir+verilog
verilog/spi_reg_pkg.sv
verilog/spi_core_pkg.sv
verilog/spi_ctrl_if.sv
verilog/spi_fifo.sv
verilog/spi_engine.sv
verilog/spi_regs.sv
verilog/spi.sv
verif/spi_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f files.f --top-module spi_tb -o spi_sim
	./obj_dir/spi_sim | tee /dev/stderr | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir

/* verif/spi_tb.sv */
`timescale 1ns/1ps
`include "spi_defs.svh"

module spi_tb;

localparam int TIMEOUT_CYCLES = 20000;   // 16 transfers at divider 7 plus polling

logic        clk;
logic        rst_n;
logic        wb_cyc;
logic        wb_stb;
logic        wb_we;
logic [11:0] wb_adr;
logic [31:0] wb_dat_w;
logic [31:0] wb_dat_r;
logic        wb_ack;
logic        wb_err;
logic        irq;
logic        sck;
logic        mosi;
logic        miso;
logic        ss0;
logic        ss1;

logic        exp_cpol;     // shadow of cr as the DUT holds it
logic        exp_ss;
logic        exp_txfeie;
logic        last_ack;
logic        last_err;
logic        bus_req;
logic        adr_valid;
int          checks;
int          errors;
int          prop_errors;
int          cycle_cnt;
int          ss0_cycles;
int          ss1_cycles;
string       reg_names [7] = '{"cr", "sr", "tdr", "rdr", "cdr", "ier", "isr"};

assign miso      = mosi;   // loopback
assign bus_req   = wb_cyc && wb_stb && !wb_ack && !wb_err;
assign adr_valid = (wb_adr < 12'h01c) && (wb_adr[1:0] == 2'b00);

spi spi_inst (
    .clk,
    .rst_n,
    .wb_cyc,
    .wb_stb,
    .wb_we,
    .wb_adr,
    .wb_dat_w,
    .wb_dat_r,
    .wb_ack,
    .wb_err,
    .irq,
    .sck,
    .mosi,
    .miso,
    .ss0,
    .ss1
);

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
        $display("timeout after %0d cycles, the run did not complete", TIMEOUT_CYCLES);
        $display("checks %0d, errors %0d, property errors %0d", checks, errors, prop_errors);
        $display("=== FAIL ===");
        $finish;
    end
end

always @(posedge clk) begin
    if (rst_n && !ss0)
        ss0_cycles++;
    if (rst_n && !ss1)
        ss1_cycles++;
end

// bus protocol
valid_acked: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req && adr_valid |=> wb_ack && !wb_err)
    else begin
        prop_errors++;
        $display("Fail wb_ack/wb_err: got %h/%h expected 1/0", $sampled(wb_ack), $sampled(wb_err));
    end

invalid_errs: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req && !adr_valid |=> wb_err && !wb_ack)
    else begin
        prop_errors++;
        $display("Fail wb_ack/wb_err: got %h/%h expected 0/1", $sampled(wb_ack), $sampled(wb_err));
    end

answer_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_ack || wb_err) |=> !(wb_ack || wb_err))
    else begin
        prop_errors++;
        $display("bus answer was held longer than one cycle");
    end

// spi pins
one_select: assert property (@(posedge clk) disable iff (!rst_n) ss0 || ss1)
    else begin
        prop_errors++;
        $display("ss0 and ss1 were low at the same time");
    end

ss0_named: assert property (@(posedge clk) disable iff (!rst_n) !ss0 |-> !exp_ss)
    else begin
        prop_errors++;
        $display("Fail ss0: got %h while active_ss is %h", $sampled(ss0), $sampled(exp_ss));
    end

ss1_named: assert property (@(posedge clk) disable iff (!rst_n) !ss1 |-> exp_ss)
    else begin
        prop_errors++;
        $display("Fail ss1: got %h while active_ss is %h", $sampled(ss1), $sampled(exp_ss));
    end

sck_idle: assert property (@(posedge clk) disable iff (!rst_n) ss0 && ss1 |-> sck == exp_cpol)
    else begin
        prop_errors++;
        $display("Fail sck: got %h expected %h", $sampled(sck), $sampled(exp_cpol));
    end

irq_gated: assert property (@(posedge clk) disable iff (!rst_n) !exp_txfeie |-> !irq)
    else begin
        prop_errors++;
        $display("Fail irq: got %h expected 0 with txfeie clear", $sampled(irq));
    end

task automatic expect_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
        else begin
            errors++;
            $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
        end
endtask

// request already taken on the edge before this is called
task automatic await_answer();
    int waited;
    waited = 1;
    while (!wb_ack && !wb_err && waited < 4) begin
        @(posedge clk);
        waited++;
    end
    last_ack = wb_ack;
    last_err = wb_err;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    if (!wb_ack && !wb_err) begin
        errors++;
        $display("no bus answer within %0d cycles at offset 0x%h", waited, wb_adr);
    end else begin
        expect_word("wb_ack/wb_err delay", 32'(waited), 32'd2);
    end
endtask

task automatic wb_write(input logic [11:0] adr, input logic [31:0] data);
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= adr;
    wb_dat_w <= data;
    @(posedge clk);
    if (adr == `SPI_CR_OFFSET) begin   // DUT register updates on this edge too
        exp_ss   <= data[0];
        exp_cpol <= data[1];
    end
    if (adr == `SPI_IER_OFFSET)
        exp_txfeie <= data[0];
    await_answer();
endtask

task automatic wb_read(input logic [11:0] adr, output logic [31:0] data);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    @(posedge clk);
    await_answer();
    data = wb_dat_r;
endtask

task automatic wait_rx_ready();
    logic [31:0] sr;
    sr = 32'h4;
    while (sr[2])
        wb_read(`SPI_SR_OFFSET, sr);   // rx_fifo_empty
endtask

task automatic loopback_mode(input logic cpol, input logic cpha, input logic ss,
                             input logic [7:0] div);
    logic [7:0]  sent_q [$];
    logic [7:0]  b;
    logic [31:0] rd;
    wb_write(`SPI_CDR_OFFSET, {24'b0, div});
    wb_write(`SPI_CR_OFFSET, {29'b0, cpha, cpol, ss});
    for (int i = 0; i < 4; i++) begin
        b = 8'($urandom);
        sent_q.push_back(b);
        wb_write(`SPI_TDR_OFFSET, {24'b0, b});
    end
    while (sent_q.size() > 0) begin
        wait_rx_ready();
        wb_read(`SPI_RDR_OFFSET, rd);
        expect_word("rdr", rd, {24'b0, sent_q.pop_front()});
    end
endtask

initial begin
    logic [31:0] rd;
    void'($urandom(79));
    rst_n      = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    exp_cpol   = 1'b0;
    exp_ss     = 1'b0;
    exp_txfeie = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // reset state
    expect_word("irq", {31'b0, irq}, 32'h0);
    expect_word("ss0", {31'b0, ss0}, 32'h1);
    expect_word("ss1", {31'b0, ss1}, 32'h1);
    expect_word("sck", {31'b0, sck}, 32'h0);
    for (int a = 0; a < 7; a++) begin
        wb_read(12'(a * 4), rd);
        expect_word(reg_names[a], rd, (a == 1) ? 32'h5 : 32'h0);
    end

    // readback masked to defined bits
    wb_write(`SPI_CR_OFFSET, 32'hffff_ffff);
    wb_read(`SPI_CR_OFFSET, rd);
    expect_word("cr", rd, 32'h7);
    wb_write(`SPI_CDR_OFFSET, 32'h1234_56a5);
    wb_read(`SPI_CDR_OFFSET, rd);
    expect_word("cdr", rd, 32'ha5);
    wb_write(`SPI_IER_OFFSET, 32'hffff_fffe);
    wb_read(`SPI_IER_OFFSET, rd);
    expect_word("ier", rd, 32'h0);
    wb_write(`SPI_IER_OFFSET, 32'hffff_ffff);
    wb_read(`SPI_IER_OFFSET, rd);
    expect_word("ier", rd, 32'h1);
    wb_write(`SPI_IER_OFFSET, 32'h0);

    loopback_mode(1'b0, 1'b0, 1'b0, 8'd7);
    loopback_mode(1'b0, 1'b1, 1'b1, 8'd3);
    loopback_mode(1'b1, 1'b0, 1'b1, 8'd0);
    loopback_mode(1'b1, 1'b1, 1'b0, 8'd5);

    // tx drain interrupt
    wb_write(`SPI_ISR_OFFSET, 32'h1);
    wb_write(`SPI_IER_OFFSET, 32'h1);
    expect_word("irq", {31'b0, irq}, 32'h0);
    wb_write(`SPI_TDR_OFFSET, 32'h5a);
    while (!irq)
        @(posedge clk);
    wb_read(`SPI_ISR_OFFSET, rd);
    expect_word("isr", rd, 32'h1);
    wb_write(`SPI_ISR_OFFSET, 32'h1);
    expect_word("irq", {31'b0, irq}, 32'h0);
    wait_rx_ready();
    wb_read(`SPI_RDR_OFFSET, rd);
    expect_word("rdr", rd, 32'h5a);

    wb_write(`SPI_IER_OFFSET, 32'h0);   // flag still sets, irq stays low
    wb_write(`SPI_TDR_OFFSET, 32'hc3);
    wait_rx_ready();
    wb_read(`SPI_RDR_OFFSET, rd);
    expect_word("rdr", rd, 32'hc3);
    wb_read(`SPI_ISR_OFFSET, rd);
    expect_word("isr", rd, 32'h1);
    wb_write(`SPI_ISR_OFFSET, 32'h1);

    // offsets outside the map
    wb_write(`SPI_CR_OFFSET, 32'h5);
    wb_write(12'h01c, 32'hffff_ffff);
    expect_word("wb_err", {31'b0, last_err}, 32'h1);
    expect_word("wb_ack", {31'b0, last_ack}, 32'h0);
    wb_read(12'h01c, rd);
    expect_word("wb_err", {31'b0, last_err}, 32'h1);
    wb_write(12'h002, 32'h2);
    expect_word("wb_err", {31'b0, last_err}, 32'h1);
    wb_read(`SPI_CR_OFFSET, rd);
    expect_word("cr", rd, 32'h5);

    if (ss0_cycles == 0 || ss1_cycles == 0) begin
        errors++;
        $display("a slave select was never driven low during the transfers");
    end
    $display("checks %0d, errors %0d, property errors %0d", checks, errors, prop_errors);
    if (errors == 0 && prop_errors == 0) begin
        $display("=== PASS ===");
    end else begin
        $display("=== FAIL ===");
    end
    $finish;
end

endmodule

/* verilog/spi.sv */
`timescale 1ns/1ps
`include "spi_defs.svh"

module spi (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`SPI_ADDR_W-1:0] wb_adr,
    input  logic [31:0]            wb_dat_w,
    output logic [31:0]            wb_dat_r,
    output logic                   wb_ack,
    output logic                   wb_err,
    output logic                   irq,
    output logic                   sck,
    output logic                   mosi,
    input  logic                   miso,
    output logic                   ss0,
    output logic                   ss1
);

spi_ctrl_if ctrl_if (.clk);

spi_regs u_regs (
    .clk,
    .rst_n,
    .wb_cyc,
    .wb_stb,
    .wb_we,
    .wb_adr,
    .wb_dat_w,
    .wb_dat_r,
    .wb_ack,
    .wb_err,
    .irq,
    .ctrl(ctrl_if.regs)
);

spi_engine u_engine (
    .clk,
    .rst_n,
    .miso,
    .sck,
    .mosi,
    .ss0,
    .ss1,
    .ctrl(ctrl_if.engine)
);

endmodule

/* verilog/spi_regs.sv */
`timescale 1ns/1ps
`include "spi_defs.svh"

module spi_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`SPI_ADDR_W-1:0] wb_adr,
    input  logic [31:0]            wb_dat_w,
    output logic [31:0]            wb_dat_r,
    output logic                   wb_ack,
    output logic                   wb_err,
    output logic                   irq,
    spi_ctrl_if.regs               ctrl
);

spi_reg_pkg::spi_regs_t regs;
spi_reg_pkg::spi_regs_t regs_nxt;
spi_reg_pkg::reg_addr_e addr;
logic                   req;
logic                   addr_ok;
logic                   wr;
logic                   rd;
logic [31:0]            rd_word;

assign addr = spi_reg_pkg::reg_addr_e'(wb_adr);
assign req  = wb_cyc && wb_stb && !wb_ack && !wb_err;   // one answer per request
assign wr   = req && addr_ok && wb_we;
assign rd   = req && addr_ok && !wb_we;

assign irq = regs.ier.txfeie & regs.isr.txfef;

assign ctrl.tx_wdata  = regs.tdr;
assign ctrl.cpol      = regs.cr.cpol;
assign ctrl.cpha      = regs.cr.cpha;
assign ctrl.active_ss = regs.cr.active_ss;
assign ctrl.divider   = regs.cdr;

always_comb begin
    case (addr)
        spi_reg_pkg::REG_CR,
        spi_reg_pkg::REG_SR,
        spi_reg_pkg::REG_TDR,
        spi_reg_pkg::REG_RDR,
        spi_reg_pkg::REG_CDR,
        spi_reg_pkg::REG_IER,
        spi_reg_pkg::REG_ISR: addr_ok = 1'b1;
        default:              addr_ok = 1'b0;
    endcase
end

always_comb begin
    regs_nxt = regs;

    if (wr) begin
        case (addr)
            spi_reg_pkg::REG_CR:  regs_nxt.cr  = spi_reg_pkg::cr_t'({29'b0, wb_dat_w[2:0]});
            spi_reg_pkg::REG_TDR: regs_nxt.tdr = wb_dat_w[`SPI_DATA_W-1:0];
            spi_reg_pkg::REG_CDR: regs_nxt.cdr = wb_dat_w[7:0];
            spi_reg_pkg::REG_IER: regs_nxt.ier = spi_reg_pkg::ier_t'({31'b0, wb_dat_w[0]});
            spi_reg_pkg::REG_ISR: begin
                if (wb_dat_w[0])
                    regs_nxt.isr.txfef = 1'b0;          // write 1 to clear
            end
            default: ;                                  // sr and rdr are read only
        endcase
    end

    regs_nxt.sr.tx_fifo_empty = ctrl.tx_empty;
    regs_nxt.sr.tx_fifo_full  = ctrl.tx_full;
    regs_nxt.sr.rx_fifo_empty = ctrl.rx_empty;
    regs_nxt.sr.rx_fifo_full  = ctrl.rx_full;

    regs_nxt.rdr = ctrl.rx_empty ? '0 : ctrl.rx_rdata;

    // tx fifo just drained, wins over a clear in the same cycle
    if (!regs.sr.tx_fifo_empty && ctrl.tx_empty)
        regs_nxt.isr.txfef = 1'b1;
end

always_comb begin
    case (addr)
        spi_reg_pkg::REG_CR:  rd_word = regs.cr;
        spi_reg_pkg::REG_SR:  rd_word = regs.sr;
        spi_reg_pkg::REG_TDR: rd_word = {24'b0, regs.tdr};
        spi_reg_pkg::REG_RDR: rd_word = {24'b0, regs_nxt.rdr};  // head before the pop
        spi_reg_pkg::REG_CDR: rd_word = {24'b0, regs.cdr};
        spi_reg_pkg::REG_IER: rd_word = regs.ier;
        spi_reg_pkg::REG_ISR: rd_word = regs.isr;
        default:              rd_word = '0;
    endcase
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        regs                  <= '0;
        regs.sr.tx_fifo_empty <= 1'b1;
        regs.sr.rx_fifo_empty <= 1'b1;
        wb_ack                <= 1'b0;
        wb_err                <= 1'b0;
        wb_dat_r              <= '0;
        ctrl.tx_push          <= 1'b0;
        ctrl.rx_pop           <= 1'b0;
        ctrl.divider_load     <= 1'b0;
    end else begin
        regs              <= regs_nxt;
        wb_ack            <= req && addr_ok;
        wb_err            <= req && !addr_ok;
        ctrl.tx_push      <= wr && (addr == spi_reg_pkg::REG_TDR);
        ctrl.rx_pop       <= rd && (addr == spi_reg_pkg::REG_RDR);
        ctrl.divider_load <= wr && (addr == spi_reg_pkg::REG_CDR);
        if (rd)
            wb_dat_r <= rd_word;
    end
end

endmodule

/* verilog/spi_engine.sv */
`timescale 1ns/1ps
`include "spi_defs.svh"

module spi_engine (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       miso,
    output logic       sck,
    output logic       mosi,
    output logic       ss0,
    output logic       ss1,
    spi_ctrl_if.engine ctrl
);

spi_core_pkg::engine_state_e state;
spi_reg_pkg::cdr_t           div_q;      // divider in use
spi_reg_pkg::cdr_t           hp_cnt;     // half period down counter
logic [3:0]                  edge_cnt;
logic [`SPI_DATA_W-1:0]      tx_sr;
logic [`SPI_DATA_W-1:0]      rx_sr;
logic [`SPI_DATA_W-1:0]      tx_head;
logic                        ss_sel;
logic                        sck_phase;
logic                        tick;
logic                        active;
logic                        start;
logic                        sck_edge;
logic                        sample_edge;
logic                        shift_edge;
logic                        tx_pop;
logic                        rx_push;

spi_fifo #(
    .DEPTH(`SPI_FIFO_DEPTH)
) tx_fifo (
    .clk,
    .rst_n,
    .push(ctrl.tx_push),
    .pop(tx_pop),
    .wdata(ctrl.tx_wdata),
    .rdata(tx_head),
    .full(ctrl.tx_full),
    .empty(ctrl.tx_empty)
);

spi_fifo #(
    .DEPTH(`SPI_FIFO_DEPTH)
) rx_fifo (
    .clk,
    .rst_n,
    .push(rx_push),
    .pop(ctrl.rx_pop),
    .wdata(rx_sr),
    .rdata(ctrl.rx_rdata),
    .full(ctrl.rx_full),
    .empty(ctrl.rx_empty)
);

// a full rx fifo keeps the engine parked
assign start = (state == spi_core_pkg::ST_IDLE) && !ctrl.tx_empty && !ctrl.rx_full;
assign tick  = (state != spi_core_pkg::ST_IDLE) && (hp_cnt == '0);

assign sck_edge = (state == spi_core_pkg::ST_SHIFT) && tick;

// cpha 0 samples on even edges, cpha 1 on odd ones
assign sample_edge = sck_edge && (edge_cnt[0] == ctrl.cpha);
// the first edge never shifts, bit 7 is already on mosi from lead
assign shift_edge  = sck_edge && (edge_cnt[0] != ctrl.cpha) && (edge_cnt != 4'd0);

// byte is done once the trail half period expires
assign tx_pop  = (state == spi_core_pkg::ST_TRAIL) && tick;
assign rx_push = tx_pop;

assign active = (state == spi_core_pkg::ST_LEAD) || (state == spi_core_pkg::ST_SHIFT);
assign ss0    = !(active && !ss_sel);
assign ss1    = !(active && ss_sel);
assign sck    = ctrl.cpol ^ sck_phase;   // idles at cpol
assign mosi   = active && tx_sr[`SPI_DATA_W-1];

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        state     <= spi_core_pkg::ST_IDLE;
        div_q     <= '0;
        hp_cnt    <= '0;
        edge_cnt  <= '0;
        ss_sel    <= 1'b0;
        sck_phase <= 1'b0;
    end else begin
        if (ctrl.divider_load)
            div_q <= ctrl.divider;

        if (state == spi_core_pkg::ST_IDLE || tick)
            hp_cnt <= div_q;
        else
            hp_cnt <= hp_cnt - 1'b1;

        case (state)
            spi_core_pkg::ST_IDLE: begin
                if (start) begin
                    state    <= spi_core_pkg::ST_LEAD;
                    ss_sel   <= ctrl.active_ss;
                    edge_cnt <= '0;
                end
            end
            spi_core_pkg::ST_LEAD: begin
                if (tick)
                    state <= spi_core_pkg::ST_SHIFT;
            end
            spi_core_pkg::ST_SHIFT: begin
                if (tick) begin
                    sck_phase <= ~sck_phase;
                    edge_cnt  <= edge_cnt + 1'b1;
                    if (edge_cnt == 4'd15)
                        state <= spi_core_pkg::ST_TRAIL;   // sck back at cpol
                end
            end
            spi_core_pkg::ST_TRAIL: begin
                if (tick)
                    state <= spi_core_pkg::ST_IDLE;
            end
            default: state <= spi_core_pkg::ST_IDLE;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (start)
        tx_sr <= tx_head;                                // msb first
    else if (shift_edge)
        tx_sr <= {tx_sr[`SPI_DATA_W-2:0], 1'b0};
    if (sample_edge)
        rx_sr <= {rx_sr[`SPI_DATA_W-2:0], miso};
end

endmodule

/* verilog/spi_fifo.sv */
`timescale 1ns/1ps
`include "spi_defs.svh"

module spi_fifo #(
    parameter int DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   push,
    input  logic                   pop,
    input  logic [`SPI_DATA_W-1:0] wdata,
    output logic [`SPI_DATA_W-1:0] rdata,
    output logic                   full,
    output logic                   empty
);

localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CNT_W = $clog2(DEPTH + 1);

logic [`SPI_DATA_W-1:0] mem [DEPTH];
logic [PTR_W-1:0]       wr_ptr;
logic [PTR_W-1:0]       rd_ptr;
logic [CNT_W-1:0]       count;
logic                   do_push;
logic                   do_pop;

assign full    = (count == CNT_W'(DEPTH));
assign empty   = (count == '0);
assign do_push = push && !full;     // overflow is dropped
assign do_pop  = pop && !empty;     // underflow is ignored
assign rdata   = mem[rd_ptr];

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (do_push)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        if (do_pop)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        if (do_push && !do_pop)
            count <= count + 1'b1;
        else if (do_pop && !do_push)
            count <= count - 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (do_push)
        mem[wr_ptr] <= wdata;
end

endmodule

/* verilog/spi_ctrl_if.sv */
`timescale 1ns/1ps
`include "spi_defs.svh"

interface spi_ctrl_if (
    input logic clk
);

    logic                   tx_push;
    logic [`SPI_DATA_W-1:0] tx_wdata;
    logic                   rx_pop;
    logic                   cpol;
    logic                   cpha;
    logic                   active_ss;
    spi_reg_pkg::cdr_t      divider;
    logic                   divider_load;   // one cycle pulse after a cdr write

    logic                   tx_full;
    logic                   tx_empty;
    logic                   rx_full;
    logic                   rx_empty;
    logic [`SPI_DATA_W-1:0] rx_rdata;       // rx fifo head

    modport regs (
        input  clk, tx_full, tx_empty, rx_full, rx_empty, rx_rdata,
        output tx_push, tx_wdata, rx_pop, cpol, cpha, active_ss, divider, divider_load
    );

    modport engine (
        input  clk, tx_push, tx_wdata, rx_pop, cpol, cpha, active_ss, divider, divider_load,
        output tx_full, tx_empty, rx_full, rx_empty, rx_rdata
    );

endinterface

/* verilog/spi_core_pkg.sv */
package spi_core_pkg;

// one transfer walks lead -> shift -> trail, then back to idle
typedef enum logic [1:0] {
    ST_IDLE,
    ST_LEAD,    // select low, sck still at cpol
    ST_SHIFT,   // sixteen sck edges
    ST_TRAIL    // select released for one half period
} engine_state_e;

endpackage

/* verilog/spi_reg_pkg.sv */
`include "spi_defs.svh"

package spi_reg_pkg;

typedef enum logic [`SPI_ADDR_W-1:0] {
    REG_CR  = `SPI_CR_OFFSET,
    REG_SR  = `SPI_SR_OFFSET,
    REG_TDR = `SPI_TDR_OFFSET,
    REG_RDR = `SPI_RDR_OFFSET,
    REG_CDR = `SPI_CDR_OFFSET,
    REG_IER = `SPI_IER_OFFSET,
    REG_ISR = `SPI_ISR_OFFSET
} reg_addr_e;

typedef struct packed {
    logic [28:0] rsvd;
    logic        cpha;
    logic        cpol;
    logic        active_ss;  // 0 selects ss0, 1 selects ss1
} cr_t;

typedef struct packed {
    logic [27:0] rsvd;
    logic        rx_fifo_full;
    logic        rx_fifo_empty;
    logic        tx_fifo_full;
    logic        tx_fifo_empty;
} sr_t;

typedef logic [7:0] cdr_t;  // sck half period is value + 1 clocks

typedef struct packed {
    logic [30:0] rsvd;
    logic        txfeie;
} ier_t;

typedef struct packed {
    logic [30:0] rsvd;
    logic        txfef;
} isr_t;

typedef struct packed {
    cr_t                   cr;
    sr_t                   sr;
    logic [`SPI_DATA_W-1:0] tdr;  // last byte written
    logic [`SPI_DATA_W-1:0] rdr;  // head of rx fifo, 0 when empty
    cdr_t                  cdr;
    ier_t                  ier;
    isr_t                  isr;
} spi_regs_t;

endpackage

/* verilog/spi_defs.svh */
`ifndef SPI_DEFS_SVH
`define SPI_DEFS_SVH

// register map, byte offsets within the peripheral window
`define SPI_CR_OFFSET   12'h000
`define SPI_SR_OFFSET   12'h004
`define SPI_TDR_OFFSET  12'h008
`define SPI_RDR_OFFSET  12'h00c
`define SPI_CDR_OFFSET  12'h010
`define SPI_IER_OFFSET  12'h014
`define SPI_ISR_OFFSET  12'h018

`define SPI_ADDR_W      12      // decoded offset bits
`define SPI_FIFO_DEPTH  8       // entries per fifo
`define SPI_DATA_W      8       // one spi word

`endif
